/* sources.f */
verilog/mips_pkg.sv
verilog/rob_cfg_pkg.sv
verilog/completion_if.sv
verilog/rob_alloc.sv
verilog/rob_slot.sv
verilog/rob_commit.sv
verilog/reorder_buffer.sv
bench/tb_reorder_buffer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the reorder buffer testbench under Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal \
    --top-module tb_reorder_buffer \
    -f sources.f \
    -o tb_reorder_buffer

# exit status of the model is not trusted, the log decides
./obj_dir/tb_reorder_buffer | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

/* bench/tb_reorder_buffer.sv */
//####################
// table-driven testbench for the reorder buffer
// phys_dest values come from an LFSR, everything else from the table
// expected phys values are tracked in dispatch order
//####################

`timescale 1ns/1ps

module tb_reorder_buffer;

    localparam int          CLK_PERIOD   = 8;
    localparam int          RESET_CYCLES = 3;
    localparam int          STEP_MAX     = 96;
    localparam int          SLACK_CYCLES = 20;
    localparam logic [31:0] LFSR_SEED    = 32'd73312;
    localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1

    typedef enum logic [1:0] {
        ACT_IDLE,
        ACT_ENQ,
        ACT_EXE,
        ACT_MEM
    } action_t;

    // one row, stimulus first, then the outputs seen in that cycle
    typedef struct packed {
        action_t               act;
        mips_pkg::entry_kind_t kind;
        mips_pkg::arch_reg_t   arch;
        logic [31:0]           addr;      // enqueue pc or exe target
        rob_cfg_pkg::rob_tag_t tag;
        logic                  redir;
        logic                  exp_cv;
        logic                  exp_sys;
        mips_pkg::arch_reg_t   exp_arch;  // don't care unless exp_cv
        logic                  exp_flush;
        logic [31:0]           exp_pc;
        logic                  ptr_care;
        logic                  exp_full;
        rob_cfg_pkg::rob_tag_t exp_enq_tag;
        rob_cfg_pkg::rob_tag_t exp_head_tag;
    } step_t;

    logic                      clk;
    logic                      reset;
    logic                      enq_valid;
    mips_pkg::entry_kind_t     enq_kind;
    logic                      enq_reg_write;
    mips_pkg::arch_reg_t       enq_arch_dest;
    mips_pkg::phys_reg_t       enq_phys_dest;
    logic [31:0]               enq_pc;
    rob_cfg_pkg::rob_tag_t     enq_tag;
    logic                      rob_full;
    logic                      exe_valid;
    rob_cfg_pkg::rob_tag_t     exe_tag;
    logic                      exe_redirect;
    logic [31:0]               exe_target;
    logic                      mem_valid;
    rob_cfg_pkg::rob_tag_t     mem_tag;
    logic                      commit_valid;
    logic                      commit_reg_write;
    mips_pkg::arch_reg_t       commit_arch_dest;
    mips_pkg::phys_reg_t       commit_phys_dest;
    logic                      commit_syscall;
    logic                      flush;
    logic [31:0]               redirect_pc;
    rob_cfg_pkg::rob_tag_t     head_tag;

    step_t                     steps [STEP_MAX];
    int                        n_steps = 0;
    int                        checks  = 0;
    int                        errors  = 0;
    logic [31:0]               lfsr_state;
    mips_pkg::phys_reg_t       phys_model [$];  // accepted entries, oldest first
    logic                      rw_model [$];    // reg_write of the same entries

    reorder_buffer u_dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ LFSR_TAPS;
        end
        return next;
    endfunction

    // one LFSR step per bit
    task automatic draw_phys(output mips_pkg::phys_reg_t value);
        value = '0;
        for (int b = 0; b < mips_pkg::PHYS_REG_W; b++) begin
            value      = {value[mips_pkg::PHYS_REG_W-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic add_enq(input mips_pkg::entry_kind_t kind, input int arch, input int pc);
        steps[n_steps].act  = ACT_ENQ;
        steps[n_steps].kind = kind;
        steps[n_steps].arch = mips_pkg::arch_reg_t'(arch);
        steps[n_steps].addr = 32'(pc);
        n_steps++;
    endtask

    task automatic add_cpl(input action_t act, input int tag, input logic redir,
                           input int target);
        steps[n_steps].act   = act;
        steps[n_steps].tag   = rob_cfg_pkg::rob_tag_t'(tag);
        steps[n_steps].redir = redir;
        steps[n_steps].addr  = 32'(target);
        n_steps++;
    endtask

    task automatic add_idle(input int count);
        n_steps += count;  // rows start out idle
    endtask

    task automatic expect_commit(input int idx, input int arch, input logic sys);
        steps[idx].exp_cv   = 1'b1;
        steps[idx].exp_sys  = sys;
        steps[idx].exp_arch = mips_pkg::arch_reg_t'(arch);
    endtask

    task automatic expect_flush(input int idx, input int pc);
        steps[idx].exp_flush = 1'b1;
        steps[idx].exp_pc    = 32'(pc);
    endtask

    task automatic expect_ptrs(input int idx, input logic full, input int enq, input int head);
        steps[idx].ptr_care     = 1'b1;
        steps[idx].exp_full     = full;
        steps[idx].exp_enq_tag  = rob_cfg_pkg::rob_tag_t'(enq);
        steps[idx].exp_head_tag = rob_cfg_pkg::rob_tag_t'(head);
    endtask

    task automatic build_table();
        int base;
        for (int i = 0; i < STEP_MAX; i++) begin
            steps[i] = '0;
        end
        add_idle(1);
        expect_ptrs(0, 1'b0, 0, 0);

        // out-of-order completion, in-order retire
        base = n_steps;
        add_enq(mips_pkg::KIND_ALU, 1, 'h100);
        add_enq(mips_pkg::KIND_ALU, 2, 'h104);
        add_enq(mips_pkg::KIND_ALU, 3, 'h108);
        add_cpl(ACT_MEM, 2, 1'b0, 0);
        add_cpl(ACT_MEM, 1, 1'b0, 0);
        add_cpl(ACT_EXE, 0, 1'b0, 0);
        add_idle(5);
        expect_ptrs(base + 3, 1'b0, 3, 0);
        expect_commit(base + 7, 1, 1'b0);
        expect_commit(base + 8, 2, 1'b0);
        expect_commit(base + 9, 3, 1'b0);
        expect_ptrs(base + 10, 1'b0, 3, 3);

        // fill to the brim, then drain
        base = n_steps;
        for (int k = 0; k < rob_cfg_pkg::ROB_DEPTH; k++) begin
            add_enq(mips_pkg::KIND_ALU, 4 + k, 'h200 + 4 * k);
        end
        add_enq(mips_pkg::KIND_ALU, 31, 'h2fc);  // dropped
        expect_ptrs(base + 16, 1'b1, 3, 3);
        add_cpl(ACT_EXE, 3, 1'b0, 0);
        expect_ptrs(base + 17, 1'b1, 3, 3);
        add_idle(1);
        expect_commit(base + 19, 4, 1'b0);
        expect_ptrs(base + 19, 1'b0, 3, 4);
        for (int k = 0; k < 15; k++) begin
            add_cpl(ACT_EXE, (4 + k) % 16, 1'b0, 0);
            expect_commit(base + 21 + k, 5 + k, 1'b0);
        end
        add_idle(3);
        expect_ptrs(base + 36, 1'b0, 3, 3);

        // syscall flushes with pc + 4, younger work dies
        base = n_steps;
        add_enq(mips_pkg::KIND_SYSCALL, 0, 'h300);
        add_enq(mips_pkg::KIND_ALU, 20, 'h304);
        add_enq(mips_pkg::KIND_ALU, 21, 'h308);
        add_cpl(ACT_EXE, 4, 1'b0, 0);
        add_cpl(ACT_MEM, 5, 1'b0, 0);
        add_cpl(ACT_EXE, 3, 1'b0, 0);
        add_idle(4);
        expect_commit(base + 7, 0, 1'b1);
        expect_flush(base + 7, 'h304);
        expect_ptrs(base + 8, 1'b0, 0, 0);

        // mispredict redirects once the delay slot retires
        base = n_steps;
        add_enq(mips_pkg::KIND_BRANCH, 0, 'h400);
        add_enq(mips_pkg::KIND_ALU, 22, 'h404);
        add_enq(mips_pkg::KIND_ALU, 23, 'h408);  // wrong path
        add_cpl(ACT_EXE, 0, 1'b1, 'h800);
        add_cpl(ACT_MEM, 2, 1'b0, 0);
        add_idle(2);
        add_cpl(ACT_EXE, 1, 1'b0, 0);
        add_idle(3);
        expect_commit(base + 5, 0, 1'b0);
        expect_commit(base + 9, 22, 1'b0);
        expect_flush(base + 9, 'h800);
        expect_ptrs(base + 10, 1'b0, 0, 0);

        // predicted branch, no redirect
        base = n_steps;
        add_enq(mips_pkg::KIND_BRANCH, 0, 'h500);
        add_enq(mips_pkg::KIND_ALU, 24, 'h504);
        add_cpl(ACT_EXE, 0, 1'b0, 'h900);
        add_cpl(ACT_EXE, 1, 1'b0, 0);
        add_idle(3);
        expect_commit(base + 4, 0, 1'b0);
        expect_commit(base + 5, 24, 1'b0);
        expect_ptrs(base + 6, 1'b0, 2, 2);
    endtask

    task automatic compare_value(input int step, input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERROR at %0t: step %0d %s is 0x%0h, expected 0x%0h",
                     $time, step, what, got, exp);
        end
    endtask

    task automatic check_step(input int i);
        step_t               s;
        mips_pkg::phys_reg_t exp_phys;
        logic                exp_rw;
        s      = steps[i];
        exp_rw = 1'b0;
        compare_value(i, "commit_valid", 32'(commit_valid), 32'(s.exp_cv));
        compare_value(i, "commit_syscall", 32'(commit_syscall), 32'(s.exp_sys));
        compare_value(i, "flush", 32'(flush), 32'(s.exp_flush));
        if (s.exp_flush || i == 0) begin
            compare_value(i, "redirect_pc", redirect_pc, s.exp_pc);
        end
        if (s.exp_cv) begin
            compare_value(i, "commit_arch_dest", 32'(commit_arch_dest), 32'(s.exp_arch));
            if (phys_model.size() == 0) begin
                errors++;
                $display("step %0d: a retirement was expected but no dispatched entry is left", i);
            end else begin
                exp_phys = phys_model.pop_front();
                exp_rw   = rw_model.pop_front();
                compare_value(i, "commit_phys_dest", 32'(commit_phys_dest), 32'(exp_phys));
            end
        end
        compare_value(i, "commit_reg_write", 32'(commit_reg_write), 32'(exp_rw));
        if (s.exp_flush) begin
            phys_model.delete();
            rw_model.delete();
        end
        if (s.ptr_care) begin
            compare_value(i, "rob_full", 32'(rob_full), 32'(s.exp_full));
            compare_value(i, "enq_tag", 32'(enq_tag), 32'(s.exp_enq_tag));
            compare_value(i, "head_tag", 32'(head_tag), 32'(s.exp_head_tag));
        end
    endtask

    task automatic drive_step(input int i);
        mips_pkg::phys_reg_t phys;
        enq_valid    = 1'b0;
        exe_valid    = 1'b0;
        exe_redirect = 1'b0;
        mem_valid    = 1'b0;
        case (steps[i].act)
            ACT_ENQ: begin
                draw_phys(phys);
                enq_valid     = 1'b1;
                enq_kind      = steps[i].kind;
                enq_reg_write = (steps[i].kind == mips_pkg::KIND_ALU) ||
                                (steps[i].kind == mips_pkg::KIND_MEM);
                enq_arch_dest = steps[i].arch;
                enq_phys_dest = phys;
                enq_pc        = steps[i].addr;
                // full or flushing buffer drops it
                if (phys_model.size() < rob_cfg_pkg::ROB_DEPTH && !steps[i].exp_flush) begin
                    phys_model.push_back(phys);
                    rw_model.push_back(enq_reg_write);
                end
            end
            ACT_EXE: begin
                exe_valid    = 1'b1;
                exe_tag      = steps[i].tag;
                exe_redirect = steps[i].redir;
                exe_target   = steps[i].addr;
            end
            ACT_MEM: begin
                mem_valid = 1'b1;
                mem_tag   = steps[i].tag;
            end
            default: ;
        endcase
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b0;
        enq_valid     = 1'b0;
        enq_kind      = mips_pkg::KIND_ALU;
        enq_reg_write = 1'b0;
        enq_arch_dest = '0;
        enq_phys_dest = '0;
        enq_pc        = '0;
        exe_valid     = 1'b0;
        exe_tag       = '0;
        exe_redirect  = 1'b0;
        exe_target    = '0;
        mem_valid     = 1'b0;
        mem_tag       = '0;
        lfsr_state    = LFSR_SEED;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b1;
        for (int i = 0; i < n_steps; i++) begin
            @(posedge clk);
            #1;
            check_step(i);  // outputs of the edge just passed
            drive_step(i);
        end
        $display("steps %0d, checks %0d, errors %0d", n_steps, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        #1;
        limit_ns = (n_steps + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns and was stopped", limit_ns);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* verilog/reorder_buffer.sv */
//####################
// 16-entry reorder buffer, in-order retire at one per clock
// completion tags are ROB indices, mem unit never redirects
// enqueue, completion and commit are plain strobes
//####################

`timescale 1ns/1ps

module reorder_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      enq_valid,
    input  mips_pkg::entry_kind_t     enq_kind,
    input  logic                      enq_reg_write,
    input  mips_pkg::arch_reg_t       enq_arch_dest,
    input  mips_pkg::phys_reg_t       enq_phys_dest,
    input  logic [mips_pkg::XLEN-1:0] enq_pc,
    output rob_cfg_pkg::rob_tag_t     enq_tag,
    output logic                      rob_full,
    input  logic                      exe_valid,
    input  rob_cfg_pkg::rob_tag_t     exe_tag,
    input  logic                      exe_redirect,
    input  logic [mips_pkg::XLEN-1:0] exe_target,
    input  logic                      mem_valid,
    input  rob_cfg_pkg::rob_tag_t     mem_tag,
    output logic                      commit_valid,
    output logic                      commit_reg_write,
    output mips_pkg::arch_reg_t       commit_arch_dest,
    output mips_pkg::phys_reg_t       commit_phys_dest,
    output logic                      commit_syscall,
    output logic                      flush,
    output logic [mips_pkg::XLEN-1:0] redirect_pc,
    output rob_cfg_pkg::rob_tag_t     head_tag
);

    logic [rob_cfg_pkg::ROB_DEPTH-1:0]                    slot_write;
    logic [rob_cfg_pkg::ROB_DEPTH-1:0]                    slot_clear;
    rob_cfg_pkg::rob_entry_t [rob_cfg_pkg::ROB_DEPTH-1:0] slot_entry;
    logic                                                 retire;

    completion_if exe_cpl ();
    completion_if mem_cpl ();

    assign exe_cpl.valid    = exe_valid;
    assign exe_cpl.tag      = exe_tag;
    assign exe_cpl.redirect = exe_redirect;
    assign exe_cpl.target   = exe_target;

    assign mem_cpl.valid    = mem_valid;
    assign mem_cpl.tag      = mem_tag;
    assign mem_cpl.redirect = 1'b0;  // branches resolve in exe only
    assign mem_cpl.target   = '0;

    rob_alloc u_alloc (
        .clk        (clk),
        .reset      (reset),
        .enq_valid  (enq_valid),
        .retire     (retire),
        .flush      (flush),
        .enq_tag    (enq_tag),
        .rob_full   (rob_full),
        .slot_write (slot_write)
    );

    for (genvar i = 0; i < rob_cfg_pkg::ROB_DEPTH; i++) begin : g_slot
        assign slot_clear[i] = retire && (head_tag == rob_cfg_pkg::rob_tag_t'(i));

        rob_slot #(
            .SLOT_INDEX (i)
        ) u_slot (
            .clk       (clk),
            .reset     (reset),
            .write     (slot_write[i]),
            .clear     (slot_clear[i]),
            .flush     (flush),
            .kind      (enq_kind),
            .reg_write (enq_reg_write),
            .arch_dest (enq_arch_dest),
            .phys_dest (enq_phys_dest),
            .pc        (enq_pc),
            .exe_cpl   (exe_cpl),
            .mem_cpl   (mem_cpl),
            .entry     (slot_entry[i])
        );
    end

    rob_commit u_commit (
        .clk              (clk),
        .reset            (reset),
        .entries          (slot_entry),
        .head_tag         (head_tag),
        .retire           (retire),
        .flush            (flush),
        .commit_valid     (commit_valid),
        .commit_reg_write (commit_reg_write),
        .commit_syscall   (commit_syscall),
        .commit_arch_dest (commit_arch_dest),
        .commit_phys_dest (commit_phys_dest),
        .redirect_pc      (redirect_pc)
    );

endmodule

/* verilog/rob_commit.sv */
//####################
// head side of the ROB, retires at most one entry per clock
// a syscall flushes on its own retirement, a mispredicted branch
// flushes when its delay slot retires
//####################

`timescale 1ns/1ps

module rob_commit (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  rob_cfg_pkg::rob_entry_t [rob_cfg_pkg::ROB_DEPTH-1:0] entries,
    output rob_cfg_pkg::rob_tag_t                                head_tag,
    output logic                                                 retire,
    output logic                                                 flush,
    output logic                                                 commit_valid,
    output logic                                                 commit_reg_write,
    output logic                                                 commit_syscall,
    output mips_pkg::arch_reg_t                                  commit_arch_dest,
    output mips_pkg::phys_reg_t                                  commit_phys_dest,
    output logic [mips_pkg::XLEN-1:0]                            redirect_pc
);

    typedef enum logic {
        COMMIT_NORMAL,
        COMMIT_DELAY_SLOT  // mispredicted branch retired, waiting on its delay slot
    } commit_state_t;

    commit_state_t             state;
    rob_cfg_pkg::rob_entry_t   head;
    logic [mips_pkg::XLEN-1:0] pending_target;
    logic [mips_pkg::XLEN-1:0] flush_target;
    logic                      is_syscall;
    logic                      is_mispredict;
    logic                      raise_flush;

    assign head          = entries[head_tag];
    assign is_syscall    = (head.kind == mips_pkg::KIND_SYSCALL);
    assign is_mispredict = (head.kind == mips_pkg::KIND_BRANCH) && head.redirect;

    // nothing retires while a flush is out, younger entries are dead
    assign retire      = head.valid && head.complete && !flush;
    assign raise_flush = retire && ((state == COMMIT_DELAY_SLOT) || is_syscall);

    // syscall alt_pc still holds pc + 4
    assign flush_target = (state == COMMIT_DELAY_SLOT) ? pending_target : head.alt_pc;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state            <= COMMIT_NORMAL;
            head_tag         <= '0;
            commit_valid     <= 1'b0;
            commit_reg_write <= 1'b0;
            commit_syscall   <= 1'b0;
            flush            <= 1'b0;
            redirect_pc      <= '0;
        end else begin
            commit_valid     <= retire;
            commit_reg_write <= retire && head.reg_write;
            commit_syscall   <= retire && is_syscall;
            flush            <= raise_flush;
            redirect_pc      <= raise_flush ? flush_target : '0;

            if (flush) begin
                head_tag <= '0;
                state    <= COMMIT_NORMAL;
            end else if (retire) begin
                head_tag <= head_tag + 1'b1;
                if (state == COMMIT_DELAY_SLOT) begin
                    state <= COMMIT_NORMAL;      // delay slot done, flush raised
                end else if (is_mispredict) begin
                    state <= COMMIT_DELAY_SLOT;
                end
            end
        end
    end

    // mapping for the retirement map table
    always_ff @(posedge clk) begin
        if (retire) begin
            commit_arch_dest <= head.arch_dest;
            commit_phys_dest <= head.phys_dest;
        end
        if (retire && (state == COMMIT_NORMAL) && is_mispredict) begin
            pending_target <= head.alt_pc;
        end
    end

    // once a flush lands the restarted head slot must be empty
    assert property (@(posedge clk) disable iff (!reset) flush |=> !head.valid)
        else $error("rob_commit: head entry still valid after a flush");

endmodule

/* verilog/rob_slot.sv */
//####################
// single ROB entry, answers to completions tagged SLOT_INDEX
// only the exe port may redirect, and only for branch entries
//####################

`timescale 1ns/1ps

module rob_slot #(
    parameter int unsigned SLOT_INDEX = 0
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      write,
    input  logic                      clear,
    input  logic                      flush,
    input  mips_pkg::entry_kind_t     kind,
    input  logic                      reg_write,
    input  mips_pkg::arch_reg_t       arch_dest,
    input  mips_pkg::phys_reg_t       phys_dest,
    input  logic [mips_pkg::XLEN-1:0] pc,
    completion_if.slot                exe_cpl,
    completion_if.slot                mem_cpl,
    output rob_cfg_pkg::rob_entry_t   entry
);

    logic                      valid_q;
    logic                      complete_q;
    logic                      redirect_q;
    mips_pkg::entry_kind_t     kind_q;
    logic                      reg_write_q;
    mips_pkg::arch_reg_t       arch_dest_q;
    mips_pkg::phys_reg_t       phys_dest_q;
    logic [mips_pkg::XLEN-1:0] alt_pc_q;
    logic                      exe_match;
    logic                      mem_match;
    logic                      exe_hit;
    logic                      is_branch;

    assign exe_match = exe_cpl.valid && (exe_cpl.tag == rob_cfg_pkg::rob_tag_t'(SLOT_INDEX));
    assign mem_match = mem_cpl.valid && (mem_cpl.tag == rob_cfg_pkg::rob_tag_t'(SLOT_INDEX));
    assign exe_hit   = exe_match && valid_q;
    assign is_branch = (kind_q == mips_pkg::KIND_BRANCH);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            valid_q    <= 1'b0;
            complete_q <= 1'b0;
            redirect_q <= 1'b0;
        end else if (flush || clear) begin
            valid_q    <= 1'b0;
            complete_q <= 1'b0;
            redirect_q <= 1'b0;
        end else if (write) begin
            valid_q    <= 1'b1;
            complete_q <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            if (valid_q && (exe_match || mem_match)) begin
                complete_q <= 1'b1;
            end
            if (exe_hit && is_branch) begin
                redirect_q <= exe_cpl.redirect;
            end
        end
    end

    // dispatch payload, qualified by valid_q
    always_ff @(posedge clk) begin
        if (write) begin
            kind_q      <= kind;
            reg_write_q <= reg_write;
            arch_dest_q <= arch_dest;
            phys_dest_q <= phys_dest;
            alt_pc_q    <= pc + mips_pkg::PC_STEP;
        end else if (exe_hit && is_branch && exe_cpl.redirect) begin
            alt_pc_q <= exe_cpl.target;  // mispredict, fetch resumes here
        end
    end

    assign entry = '{
        valid:     valid_q,
        complete:  complete_q,
        kind:      kind_q,
        reg_write: reg_write_q,
        arch_dest: arch_dest_q,
        phys_dest: phys_dest_q,
        redirect:  redirect_q,
        alt_pc:    alt_pc_q
    };

    // a unit reporting on an empty slot has a stale or bad tag
    assert property (@(posedge clk) disable iff (!reset) (exe_match || mem_match) |-> valid_q)
        else $error("rob_slot %0d: completion for an empty entry", SLOT_INDEX);

endmodule

/* verilog/rob_alloc.sv */
//####################
// tail side of the ROB
// enqueue while full is dropped silently, full is the only back-pressure
// an enqueue in a flush cycle is discarded
//####################

`timescale 1ns/1ps

module rob_alloc (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  enq_valid,
    input  logic                                  retire,
    input  logic                                  flush,
    output rob_cfg_pkg::rob_tag_t                 enq_tag,
    output logic                                  rob_full,
    output logic [rob_cfg_pkg::ROB_DEPTH-1:0]     slot_write
);

    rob_cfg_pkg::rob_tag_t   tail;
    rob_cfg_pkg::rob_count_t count;
    logic                    accept;

    assign enq_tag  = tail;
    assign rob_full = (count == rob_cfg_pkg::ROB_FULL_COUNT);
    assign accept   = enq_valid && !rob_full && !flush;

    // one-hot write strobe for the slot under the tail
    always_comb begin
        slot_write = '0;
        if (accept) begin
            slot_write[tail] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            tail  <= '0;
            count <= '0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;  // wraps at depth
            end
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or one in and one out
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!reset) count <= rob_cfg_pkg::ROB_FULL_COUNT)
        else $error("rob_alloc: occupancy %0d beyond depth", count);

    // commit must never drain an empty buffer
    assert property (@(posedge clk) disable iff (!reset) retire |-> (count != '0))
        else $error("rob_alloc: retire with empty buffer");

endmodule

/* verilog/completion_if.sv */
//####################
// completion report from an execution unit to the ROB
// valid is a one-cycle strobe, tag is the ROB index
//####################

`timescale 1ns/1ps

interface completion_if;

    logic                      valid;
    rob_cfg_pkg::rob_tag_t     tag;
    logic                      redirect;  // branch resolved against prediction
    logic [mips_pkg::XLEN-1:0] target;    // resolved branch target

    modport producer (
        output valid,
        output tag,
        output redirect,
        output target
    );

    modport slot (
        input valid,
        input tag,
        input redirect,
        input target
    );

endinterface

/* verilog/rob_cfg_pkg.sv */
//####################
// reorder buffer geometry and the per-entry record
// depth must stay a power of two so the pointers wrap on their own
// relies on mips_pkg being compiled first
//####################

package rob_cfg_pkg;

    localparam int unsigned ROB_DEPTH = 16;
    localparam int unsigned ROB_TAG_W = $clog2(ROB_DEPTH);

    // entry index, doubles as the completion tag
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // occupancy needs one extra bit to reach ROB_DEPTH
    typedef logic [ROB_TAG_W:0] rob_count_t;
    localparam rob_count_t ROB_FULL_COUNT = rob_count_t'(ROB_DEPTH);

    typedef struct packed {
        logic                      valid;
        logic                      complete;
        mips_pkg::entry_kind_t     kind;
        logic                      reg_write;
        mips_pkg::arch_reg_t       arch_dest;
        mips_pkg::phys_reg_t       phys_dest;
        logic                      redirect;  // exe reported a mispredict
        logic [mips_pkg::XLEN-1:0] alt_pc;    // pc + 4, or branch target
    } rob_entry_t;

endpackage

/* verilog/mips_pkg.sv */
//####################
// core-wide widths for the out-of-order MIPS pipeline
// 32 architectural and 64 physical registers
//####################

package mips_pkg;

    localparam int unsigned XLEN       = 32;
    localparam int unsigned ARCH_REG_W = 5;
    localparam int unsigned PHYS_REG_W = 6;

    // sequential fetch step in bytes
    localparam logic [XLEN-1:0] PC_STEP = 32'd4;

    typedef logic [ARCH_REG_W-1:0] arch_reg_t;
    typedef logic [PHYS_REG_W-1:0] phys_reg_t;

    // what the ROB needs to know about an instruction at retirement
    typedef enum logic [1:0] {
        KIND_ALU     = 2'd0,
        KIND_MEM     = 2'd1,
        KIND_BRANCH  = 2'd2,  // branches and jumps
        KIND_SYSCALL = 2'd3
    } entry_kind_t;

endpackage
